/* source/cp0_pkg.sv */
package cp0_pkg;

    localparam int DATA_W = 32;

    // cp0 register numbers
    typedef enum logic [4:0] {
        REG_BADVADDR = 5'd8,
        REG_COUNT    = 5'd9,
        REG_COMPARE  = 5'd11,
        REG_STATUS   = 5'd12,
        REG_CAUSE    = 5'd13,
        REG_EPC      = 5'd14,
        REG_PRID     = 5'd15,
        REG_CONFIG   = 5'd16
    } cp0_addr_e;

    // event presented by the pipeline in a cycle
    typedef enum logic [3:0] {
        EXC_NONE, EXC_INT, EXC_ADEL, EXC_ADES,
        EXC_SYS,  EXC_BP,  EXC_RI,   EXC_OV,
        EXC_TR,   EXC_TLBL, EXC_TLBS, EXC_MOD,
        EXC_ERET
    } exc_op_e;

    // cause excode field
    typedef enum logic [4:0] {
        CODE_INT  = 5'd0,
        CODE_MOD  = 5'd1,
        CODE_TLBL = 5'd2,
        CODE_TLBS = 5'd3,
        CODE_ADEL = 5'd4,
        CODE_ADES = 5'd5,
        CODE_SYS  = 5'd8,
        CODE_BP   = 5'd9,
        CODE_RI   = 5'd10,
        CODE_OV   = 5'd12,
        CODE_TR   = 5'd13
    } exc_code_e;

    typedef enum logic {ST_NORMAL, ST_EXCEPTION} exc_state_e;

    localparam int STATUS_EXL_BIT = 1;
    localparam int CAUSE_BD_BIT   = 31;

    localparam logic [DATA_W-1:0] STATUS_RESET = 32'h1000_0000;  // cu0 set

endpackage

/* source/cp0_timer.sv */
`timescale 1ns/1ps

module cp0_timer #(
    parameter int COUNT_DIV = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  cp0_pkg::cp0_addr_e         waddr_i,
    input  logic [cp0_pkg::DATA_W-1:0] data_i,
    output logic [cp0_pkg::DATA_W-1:0] count_o,
    output logic [cp0_pkg::DATA_W-1:0] compare_o,
    output logic                       timer_int_o
);

    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

    // free running prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_o <= '0;
        end else if (we_i && waddr_i == cp0_pkg::REG_COUNT) begin
            count_o <= data_i;  // software load beats the tick
        end else if (tick) begin
            count_o <= count_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare_o   <= '0;
            timer_int_o <= 1'b0;
        end else if (we_i && waddr_i == cp0_pkg::REG_COMPARE) begin
            compare_o   <= data_i;
            timer_int_o <= 1'b0;  // writing compare acks the interrupt
        end else if (compare_o != '0 && count_o == compare_o) begin
            timer_int_o <= 1'b1;
        end
    end

    // a rising interrupt needs a nonzero compare on the edge before
    assert property (@(posedge clk) disable iff (rst)
        !timer_int_o ##1 timer_int_o |-> $past(compare_o) != '0)
        else $error("timer interrupt set with compare zero");

endmodule

/* source/cp0_exc_fsm.sv */
`timescale 1ns/1ps

module cp0_exc_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  cp0_pkg::cp0_addr_e         waddr_i,
    input  logic [cp0_pkg::DATA_W-1:0] data_i,
    input  cp0_pkg::exc_op_e           exc_op_i,
    output logic                       exl_o,
    output logic                       epc_load_o,
    output logic                       cause_load_o,
    output logic                       badvaddr_load_o,
    output cp0_pkg::exc_code_e         exc_code_o
);

    cp0_pkg::exc_state_e state, state_nxt;
    logic                exc_taken;
    logic                eret;
    logic                status_wr;

    assign exc_taken = (exc_op_i != cp0_pkg::EXC_NONE) && (exc_op_i != cp0_pkg::EXC_ERET);
    assign eret      = (exc_op_i == cp0_pkg::EXC_ERET);
    assign status_wr = we_i && (waddr_i == cp0_pkg::REG_STATUS);

    always_comb begin
        state_nxt = state;
        if (exc_taken) begin
            state_nxt = cp0_pkg::ST_EXCEPTION;
        end else if (eret) begin
            state_nxt = cp0_pkg::ST_NORMAL;
        end else if (status_wr) begin
            state_nxt = data_i[cp0_pkg::STATUS_EXL_BIT] ? cp0_pkg::ST_EXCEPTION
                                                         : cp0_pkg::ST_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cp0_pkg::ST_NORMAL;
        end else begin
            state <= state_nxt;
        end
    end

    assign exl_o        = (state == cp0_pkg::ST_EXCEPTION);
    assign epc_load_o   = exc_taken && (state == cp0_pkg::ST_NORMAL);  // no epc on nesting
    assign cause_load_o = exc_taken;

    always_comb begin
        case (exc_op_i)
            cp0_pkg::EXC_ADEL: exc_code_o = cp0_pkg::CODE_ADEL;
            cp0_pkg::EXC_ADES: exc_code_o = cp0_pkg::CODE_ADES;
            cp0_pkg::EXC_TLBL: exc_code_o = cp0_pkg::CODE_TLBL;
            cp0_pkg::EXC_TLBS: exc_code_o = cp0_pkg::CODE_TLBS;
            cp0_pkg::EXC_MOD:  exc_code_o = cp0_pkg::CODE_MOD;
            cp0_pkg::EXC_SYS:  exc_code_o = cp0_pkg::CODE_SYS;
            cp0_pkg::EXC_BP:   exc_code_o = cp0_pkg::CODE_BP;
            cp0_pkg::EXC_RI:   exc_code_o = cp0_pkg::CODE_RI;
            cp0_pkg::EXC_OV:   exc_code_o = cp0_pkg::CODE_OV;
            cp0_pkg::EXC_TR:   exc_code_o = cp0_pkg::CODE_TR;
            default:           exc_code_o = cp0_pkg::CODE_INT;
        endcase
    end

    // address and tlb faults report the failing address
    always_comb begin
        case (exc_op_i)
            cp0_pkg::EXC_ADEL, cp0_pkg::EXC_ADES, cp0_pkg::EXC_TLBL,
            cp0_pkg::EXC_TLBS, cp0_pkg::EXC_MOD: badvaddr_load_o = 1'b1;
            default:                             badvaddr_load_o = 1'b0;
        endcase
    end

    // an epc load is always a full entry, exl must follow on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        epc_load_o |-> cause_load_o ##1 exl_o)
        else $error("exception entry without cause load or exl");

endmodule

/* source/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs #(
    parameter logic [31:0] PRID_VALUE = 32'h0000_4220
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  cp0_pkg::cp0_addr_e         waddr_i,
    input  logic [cp0_pkg::DATA_W-1:0] data_i,
    input  cp0_pkg::cp0_addr_e         raddr_i,
    input  logic [2:0]                 rsel_i,
    input  logic [5:0]                 int_i,
    input  logic [cp0_pkg::DATA_W-1:0] pc_i,
    input  logic                       bd_i,
    input  logic [cp0_pkg::DATA_W-1:0] bad_vaddr_i,
    input  logic                       exl_i,
    input  logic                       epc_load_i,
    input  logic                       cause_load_i,
    input  logic                       badvaddr_load_i,
    input  cp0_pkg::exc_code_e         exc_code_i,
    input  logic [cp0_pkg::DATA_W-1:0] count_i,
    input  logic [cp0_pkg::DATA_W-1:0] compare_i,
    output logic [cp0_pkg::DATA_W-1:0] data_o
);

    // fixed config words, kseg0 cacheable
    localparam logic [cp0_pkg::DATA_W-1:0] CONFIG_VALUE  = 32'h8000_0083;
    localparam logic [cp0_pkg::DATA_W-1:0] CONFIG1_VALUE = 32'h0021_1080;

    logic [cp0_pkg::DATA_W-1:0] status_q;
    logic [cp0_pkg::DATA_W-1:0] status_rd;
    logic [cp0_pkg::DATA_W-1:0] cause_q;
    logic [cp0_pkg::DATA_W-1:0] epc_q;
    logic [cp0_pkg::DATA_W-1:0] badvaddr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= cp0_pkg::STATUS_RESET;
        end else if (we_i && waddr_i == cp0_pkg::REG_STATUS) begin
            status_q <= data_i;
        end
    end

    // exl lives in the fsm
    always_comb begin
        status_rd = status_q;
        status_rd[cp0_pkg::STATUS_EXL_BIT] = exl_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause_q <= '0;
        end else begin
            cause_q[15:10] <= int_i;  // ip7..ip2
            if (we_i && waddr_i == cp0_pkg::REG_CAUSE) begin
                cause_q[9:8] <= data_i[9:8];  // sw interrupts
                cause_q[23]  <= data_i[23];
                cause_q[22]  <= data_i[22];
            end
            if (cause_load_i) begin
                cause_q[6:2] <= exc_code_i;
            end
            if (epc_load_i) begin
                cause_q[cp0_pkg::CAUSE_BD_BIT] <= bd_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q <= '0;
        end else if (epc_load_i) begin
            epc_q <= bd_i ? pc_i - 32'd4 : pc_i;  // point back at the branch
        end else if (we_i && waddr_i == cp0_pkg::REG_EPC) begin
            epc_q <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr_q <= '0;
        end else if (badvaddr_load_i) begin
            badvaddr_q <= bad_vaddr_i;
        end else if (we_i && waddr_i == cp0_pkg::REG_BADVADDR) begin
            badvaddr_q <= data_i;
        end
    end

    always_comb begin
        case (raddr_i)
            cp0_pkg::REG_BADVADDR: data_o = badvaddr_q;
            cp0_pkg::REG_COUNT:    data_o = count_i;
            cp0_pkg::REG_COMPARE:  data_o = compare_i;
            cp0_pkg::REG_STATUS:   data_o = status_rd;
            cp0_pkg::REG_CAUSE:    data_o = cause_q;
            cp0_pkg::REG_EPC:      data_o = epc_q;
            cp0_pkg::REG_PRID: begin
                data_o = (rsel_i == 3'd0) ? PRID_VALUE : '0;
            end
            cp0_pkg::REG_CONFIG: begin
                case (rsel_i)
                    3'd0:    data_o = CONFIG_VALUE;
                    3'd1:    data_o = CONFIG1_VALUE;
                    default: data_o = '0;
                endcase
            end
            default: data_o = '0;
        endcase
    end

    // nested exceptions must keep the first return address
    assert property (@(posedge clk) disable iff (rst) epc_load_i |-> !exl_i)
        else $error("epc reloaded while exl already set");

endmodule

/* source/cp0_top.sv */
`timescale 1ns/1ps

module cp0_top #(
    parameter int          COUNT_DIV  = 2,
    parameter logic [31:0] PRID_VALUE = 32'h0000_4220
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we_i,
    input  cp0_pkg::cp0_addr_e         waddr_i,
    input  logic [cp0_pkg::DATA_W-1:0] data_i,
    input  cp0_pkg::cp0_addr_e         raddr_i,
    input  logic [2:0]                 rsel_i,
    input  logic [5:0]                 int_i,
    input  cp0_pkg::exc_op_e           exc_op_i,
    input  logic [cp0_pkg::DATA_W-1:0] pc_i,
    input  logic                       bd_i,
    input  logic [cp0_pkg::DATA_W-1:0] bad_vaddr_i,
    output logic [cp0_pkg::DATA_W-1:0] data_o,
    output logic                       timer_int_o
);

    logic [cp0_pkg::DATA_W-1:0] count;
    logic [cp0_pkg::DATA_W-1:0] compare;
    logic                       exl;
    logic                       epc_load;
    logic                       cause_load;
    logic                       badvaddr_load;
    cp0_pkg::exc_code_e         exc_code;

    cp0_timer #(.COUNT_DIV(COUNT_DIV)) u_timer (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .data_i      (data_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_exc_fsm u_exc_fsm (
        .clk (clk), .rst (rst), .we_i (we_i), .waddr_i (waddr_i), .data_i (data_i),
        .exc_op_i        (exc_op_i),
        .exl_o           (exl),
        .epc_load_o      (epc_load),
        .cause_load_o    (cause_load),
        .badvaddr_load_o (badvaddr_load),
        .exc_code_o      (exc_code)
    );

    cp0_regs #(.PRID_VALUE(PRID_VALUE)) u_regs (
        .clk (clk), .rst (rst), .we_i (we_i), .waddr_i (waddr_i), .data_i (data_i),
        .raddr_i (raddr_i), .rsel_i (rsel_i), .int_i (int_i),
        .pc_i (pc_i), .bd_i (bd_i), .bad_vaddr_i (bad_vaddr_i),
        .exl_i (exl), .epc_load_i (epc_load), .cause_load_i (cause_load),
        .badvaddr_load_i (badvaddr_load), .exc_code_i (exc_code),
        .count_i (count), .compare_i (compare),
        .data_o (data_o)
    );

endmodule

/* tests/cp0_tb.sv */
`timescale 1ns/1ps

module cp0_tb;

    localparam int COUNT_DIV     = 2;  // dut default
    localparam int CYCLES_PER_LN = 40;

    logic                       clk;
    logic                       rst;
    logic                       we_i;
    cp0_pkg::cp0_addr_e         waddr_i;
    logic [cp0_pkg::DATA_W-1:0] data_i;
    cp0_pkg::cp0_addr_e         raddr_i;
    logic [2:0]                 rsel_i;
    logic [5:0]                 int_i;
    cp0_pkg::exc_op_e           exc_op_i;
    logic [cp0_pkg::DATA_W-1:0] pc_i;
    logic                       bd_i;
    logic [cp0_pkg::DATA_W-1:0] bad_vaddr_i;
    logic [cp0_pkg::DATA_W-1:0] data_o;
    logic                       timer_int_o;

    int unsigned cycle_cnt  = 0;
    int unsigned count_edge = 0;  // edge on which count was last loaded
    logic [31:0] count_base = '0;  // value count was last loaded with
    int          line_total = 0;

    cp0_top u_cp0_top (
        .clk         (clk),
        .rst         (rst),
        .we_i        (we_i),
        .waddr_i     (waddr_i),
        .data_i      (data_i),
        .raddr_i     (raddr_i),
        .rsel_i      (rsel_i),
        .int_i       (int_i),
        .exc_op_i    (exc_op_i),
        .pc_i        (pc_i),
        .bd_i        (bd_i),
        .bad_vaddr_i (bad_vaddr_i),
        .data_o      (data_o),
        .timer_int_o (timer_int_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed line in test file, wanted %0d fields", want);
            stop_on_failure();
        end
    endtask

    task automatic drive_idle();
        we_i     <= 1'b0;
        exc_op_i <= cp0_pkg::EXC_NONE;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        drive_idle();
        we_i    <= 1'b1;
        waddr_i <= cp0_pkg::cp0_addr_e'(addr[4:0]);
        data_i  <= data;
        @(negedge clk);
        if (addr[4:0] == cp0_pkg::REG_COUNT) begin
            count_edge = cycle_cnt + 1;
            count_base = data;
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] sel,
                            input logic [31:0] exp);
        @(posedge clk);
        drive_idle();
        raddr_i <= cp0_pkg::cp0_addr_e'(addr[4:0]);
        rsel_i  <= sel[2:0];
        @(negedge clk);
        check_value($sformatf("data_o reg %0d sel %0d", addr, sel), data_o, exp);
    endtask

    task automatic apply_exception(input logic [31:0] op, input logic [31:0] pc,
                                   input logic bd, input logic [31:0] bva,
                                   input logic wr, input logic [31:0] addr,
                                   input logic [31:0] data);
        @(posedge clk);
        drive_idle();
        exc_op_i    <= cp0_pkg::exc_op_e'(op[3:0]);
        pc_i        <= pc;
        bd_i        <= bd;
        bad_vaddr_i <= bva;
        if (wr) begin
            we_i    <= 1'b1;
            waddr_i <= cp0_pkg::cp0_addr_e'(addr[4:0]);
            data_i  <= data;
        end
        @(negedge clk);
    endtask

    // filler writes go to unmapped reg 0
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            drive_idle();
            we_i    <= 1'b1;
            waddr_i <= cp0_pkg::cp0_addr_e'(5'd0);
            data_i  <= $urandom;
            @(negedge clk);
        end
    endtask

    task automatic set_int_lines(input logic [31:0] lines);
        @(posedge clk);
        drive_idle();
        int_i <= lines[5:0];
        @(negedge clk);
    endtask

    task automatic count_window_check(input logic [31:0] lo);
        logic [31:0] hi;
        logic        in_win;
        @(posedge clk);
        drive_idle();
        raddr_i <= cp0_pkg::REG_COUNT;
        rsel_i  <= 3'd0;
        @(negedge clk);
        hi     = count_base + (cycle_cnt - count_edge) / COUNT_DIV + 1;
        in_win = (data_o >= lo) && (data_o <= hi);
        if (!in_win) begin
            $display("count %h outside window %h to %h", data_o, lo, hi);
        end
        check_value("count in window", {31'b0, in_win}, 32'd1);
    endtask

    task automatic wait_timer_int(input logic exp);
        int   limit;
        int   waited;
        logic seen;
        limit  = exp ? 3 * COUNT_DIV : 1;  // a clear must show at once
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < limit) begin
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            seen   = (timer_int_o === exp);
            waited = waited + 1;
        end
        check_value("timer_int_o", {31'b0, timer_int_o}, {31'b0, exp});
    endtask

    initial begin
        wait (line_total > 0);
        repeat (line_total * CYCLES_PER_LN) @(posedge clk);
        $display("timeout, test file not finished after %0d cycles",
                 line_total * CYCLES_PER_LN);
        stop_on_failure();
    end

    initial begin
        int               fd;
        int               rc;
        int               n_lines;
        int unsigned      seed_ret;
        logic [7:0]       cmd;
        logic [31:0]      f0, f1, f2, f3, f4, f5;
        logic [8*160-1:0] line_buf;

        rst         <= 1'b1;
        we_i        <= 1'b0;
        waddr_i     <= cp0_pkg::REG_STATUS;
        data_i      <= '0;
        raddr_i     <= cp0_pkg::REG_PRID;
        rsel_i      <= 3'd0;
        int_i       <= 6'd0;
        exc_op_i    <= cp0_pkg::EXC_NONE;
        pc_i        <= '0;
        bd_i        <= 1'b0;
        bad_vaddr_i <= '0;
        seed_ret = $urandom(32'ha9c5);

        fd = $fopen("tests/cp0_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/cp0_tests.txt");
            stop_on_failure();
        end
        n_lines = 0;
        while (!$feof(fd)) begin
            rc = $fgets(line_buf, fd);
            if (rc > 0) begin
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
        line_total = n_lines;  // arms the watchdog
        fd = $fopen("tests/cp0_tests.txt", "r");

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": rc = $fgets(line_buf, fd);
                "W": begin
                    rc = $fscanf(fd, "%h %h", f0, f1);
                    expect_fields(rc, 2);
                    write_reg(f0, f1);
                end
                "R": begin
                    rc = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    expect_fields(rc, 3);
                    read_reg(f0, f1, f2);
                end
                "E": begin
                    rc = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    expect_fields(rc, 4);
                    apply_exception(f0, f1, f2[0], f3, 1'b0, '0, '0);
                end
                "X": begin
                    rc = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                    expect_fields(rc, 6);
                    apply_exception(f0, f1, f2[0], f3, 1'b1, f4, f5);
                end
                "I": begin
                    rc = $fscanf(fd, "%h", f0);
                    expect_fields(rc, 1);
                    set_int_lines(f0);
                end
                "N": begin
                    rc = $fscanf(fd, "%h", f0);
                    expect_fields(rc, 1);
                    idle_cycles(f0);
                end
                "C": begin
                    rc = $fscanf(fd, "%h", f0);
                    expect_fields(rc, 1);
                    count_window_check(f0);
                end
                "T": begin
                    rc = $fscanf(fd, "%h", f0);
                    expect_fields(rc, 1);
                    wait_timer_int(f0[0]);
                end
                default: begin
                    $display("unknown command %c in test file", cmd);
                    stop_on_failure();
                end
            endcase
        end
        $fclose(fd);
        $display("Test OK");
        $finish;
    end

endmodule

/* tests/cp0_tests.txt */
# hex fields: W addr data | R addr sel expect | E op pc bd badvaddr | I ints | N cycles
# C count_low | T timer_int | X op pc bd badvaddr addr data (exception plus write)
R 0f 0 00004220
R 10 2 00000000
W 0e 12345678
R 0e 0 12345678
W 08 deadbeef
R 08 0 deadbeef
W 0d ffffffff
R 0d 0 00c00300
W 0d 00000000
N 4
R 00 0 00000000
R 0e 0 12345678
W 09 00001000
N a
C 00001000
W 0b 00000200
W 09 000001ff
T 1
W 0b 70000000
T 0
R 0b 0 70000000
E 4 bfc00100 0 00000000
R 0e 0 bfc00100
R 0d 0 00000020
R 0c 0 10000002
E c 00000000 0 00000000
R 0c 0 10000000
E 2 80001004 1 12345673
R 0e 0 80001000
R 0d 0 80000010
R 08 0 12345673
R 0c 0 10000002
E 6 80002000 0 00000000
R 0e 0 80001000
R 0d 0 80000028
E c 00000000 0 00000000
R 0c 0 10000000
X 4 80003000 0 00000000 0c 1000ff00
R 0c 0 1000ff02
R 0e 0 80003000
I 2d
N 1
R 0d 0 0000b420

/* filelist.f */
source/cp0_pkg.sv
source/cp0_timer.sv
source/cp0_exc_fsm.sv
source/cp0_regs.sv
source/cp0_top.sv
tests/cp0_tb.sv
